// File: sources.f
verilog/zx_mem_pkg.sv
verilog/zx_bus_pkg.sv
verilog/zmem_pager.sv
verilog/req_credit_fifo.sv
verilog/dram_arbiter.sv
verilog/dram_sequencer.sv
verilog/zmem_path_top.sv
test/tb_dram_model.sv
test/tb_zmem_path.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_zmem_path
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run the simulation, check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: test/tb_zmem_path.sv
module tb_zmem_path;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CPU_DEPTH   = zx_mem_pkg::CPU_QUEUE_DEPTH;
	localparam int VIDEO_DEPTH = zx_mem_pkg::VIDEO_QUEUE_DEPTH;
	localparam int WAIT_LIMIT  = 300;
	localparam int RANDOM_OPS  = 200;

	logic                   fclk;
	logic                   reset;
	zx_bus_pkg::page_wr_t   page_wr;
	zx_bus_pkg::cpu_req_t   cpu_req;
	logic                   cpu_credit;
	zx_bus_pkg::video_req_t video_req;
	logic                   video_credit;
	zx_bus_pkg::dram_cmd_t  dram_cmd;
	zx_mem_pkg::dram_word_t dram_rddata;
	zx_bus_pkg::cpu_rsp_t   cpu_rsp;
	zx_bus_pkg::video_rsp_t video_rsp;

	// shadow page map and byte memory keyed by word address then lane
	zx_mem_pkg::page_t sh_page [zx_mem_pkg::NUM_WINDOWS];
	logic              sh_rom  [zx_mem_pkg::NUM_WINDOWS];
	zx_mem_pkg::byte_t sh_mem  [logic [21:0]];

	// expected responses in request order
	zx_mem_pkg::byte_t      cpu_exp [$];
	zx_mem_pkg::dram_word_t video_exp [$];
	int cpu_seen = 0;
	int video_seen = 0;

	int cpu_used = 0;
	int video_used = 0;
	int cpu_back = 0;
	int video_back = 0;
	int dram_writes = 0;

	int cmp_errors = 0;
	int credit_errors = 0;
	int stim_errors = 0;
	int errors_at = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int seed;
	string test_name = "reset";

	event timeout_ev;

	initial
		fclk = 1'b0;
	always #2 fclk = ~fclk;

	zmem_path_top i_zmem_path_top
	(
		.fclk         (fclk),
		.reset        (reset),
		.page_wr      (page_wr),
		.cpu_req      (cpu_req),
		.cpu_credit   (cpu_credit),
		.video_req    (video_req),
		.video_credit (video_credit),
		.dram_cmd     (dram_cmd),
		.dram_rddata  (dram_rddata),
		.cpu_rsp      (cpu_rsp),
		.video_rsp    (video_rsp)
	);

	tb_dram_model i_dram_model
	(
		.fclk        (fclk),
		.dram_cmd    (dram_cmd),
		.dram_rddata (dram_rddata)
	);

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	// window page on top of the word offset inside the window
	function automatic zx_mem_pkg::dram_addr_t translate_addr(input zx_mem_pkg::z_addr_t a);
		return {sh_page[a[15:14]], a[13:1]};
	endfunction

	function automatic zx_mem_pkg::dram_word_t shadow_word(input zx_mem_pkg::dram_addr_t w);
		return {sh_mem[{w, 1'b1}], sh_mem[{w, 1'b0}]};
	endfunction

	function automatic int cpu_avail();
		return CPU_DEPTH - cpu_used + cpu_back;
	endfunction

	function automatic int video_avail();
		return VIDEO_DEPTH - video_used + video_back;
	endfunction

	function automatic int total_errors();
		return cmp_errors + credit_errors + stim_errors;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// monitors
	////////////////////////////////////////////////////////////////////////////

	// count credit pulses and dram writes on the falling edge
	always @(negedge fclk)
	begin
		if (reset)
		begin
			cpu_back    <= 0;
			video_back  <= 0;
			dram_writes <= 0;
		end
		else
		begin
			if (cpu_credit)
				cpu_back <= cpu_back + 1;
			if (video_credit)
				video_back <= video_back + 1;
			if (dram_cmd.valid && !dram_cmd.rnw)
				dram_writes <= dram_writes + 1;
		end
	end

	always @(posedge fclk)
	begin
		if (!reset)
		begin
			assert (cpu_avail() >= 0 && cpu_avail() <= CPU_DEPTH)
			else
			begin
				$display("%s: cpu credit count left its range: %0d", test_name, cpu_avail());
				credit_errors++;
			end
			assert (video_avail() >= 0 && video_avail() <= VIDEO_DEPTH)
			else
			begin
				$display("%s: video credit count left its range: %0d", test_name, video_avail());
				credit_errors++;
			end
		end
	end

	always @(negedge fclk)
	begin : compare_rsp
		zx_mem_pkg::byte_t      exp_b;
		zx_mem_pkg::dram_word_t exp_w;
		if (!reset && cpu_rsp.valid)
		begin
			assert (cpu_seen < cpu_exp.size())
			else
			begin
				$display("%s: cpu response arrived with no read outstanding", test_name);
				cmp_errors++;
			end
			if (cpu_seen < cpu_exp.size())
			begin
				exp_b = cpu_exp[cpu_seen];
				cpu_seen++;
				assert (cpu_rsp.data == exp_b)
				else
				begin
					$display("[ERROR] %s cpu read: expected %h, actual %h",
						test_name, exp_b, cpu_rsp.data);
					cmp_errors++;
				end
			end
		end
		if (!reset && video_rsp.valid)
		begin
			assert (video_seen < video_exp.size())
			else
			begin
				$display("%s: video response arrived with no read outstanding", test_name);
				cmp_errors++;
			end
			if (video_seen < video_exp.size())
			begin
				exp_w = video_exp[video_seen];
				video_seen++;
				assert (video_rsp.data == exp_w)
				else
				begin
					$display("[ERROR] %s video read: expected %h, actual %h",
						test_name, exp_w, video_rsp.data);
					cmp_errors++;
				end
			end
		end
	end

	// ends the run once a wait gives up
	initial
	begin
		@(timeout_ev);
		$display("Test failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_on_timeout(input string what);
		$display("%s: timed out waiting for %s", test_name, what);
		-> timeout_ev;
	endtask

	// drive one cycle and record expectations as the request goes out
	task automatic drive(input logic cpu_go, input logic cpu_rnw, input zx_mem_pkg::z_addr_t a,
		input zx_mem_pkg::byte_t d, input logic video_go, input zx_mem_pkg::dram_addr_t va);
		zx_mem_pkg::dram_word_t w;
		@(negedge fclk);
		page_wr.valid = 1'b0;
		cpu_req       = '{valid: cpu_go, rnw: cpu_rnw, addr: a, wrdata: d};
		video_req     = '{valid: video_go, addr: va};
		if (cpu_go && cpu_rnw)
		begin
			w = shadow_word(translate_addr(a));
			cpu_exp.push_back(a[0] ? w[15:8] : w[7:0]);
		end
		// rom windows keep the shadow as it was
		else if (cpu_go && !sh_rom[a[15:14]])
			sh_mem[{translate_addr(a), a[0]}] = d;
		if (cpu_go)
			cpu_used++;
		if (video_go)
		begin
			video_used++;
			video_exp.push_back(shadow_word(va));
		end
	endtask

	task automatic idle();
		drive(1'b0, 1'b1, '0, '0, 1'b0, '0);
	endtask

	task automatic send(input logic cpu_go, input logic cpu_rnw, input zx_mem_pkg::z_addr_t a,
		input zx_mem_pkg::byte_t d, input logic video_go, input zx_mem_pkg::dram_addr_t va);
		int n;
		n = 0;
		while ((cpu_go && cpu_avail() == 0) || (video_go && video_avail() == 0))
		begin
			if (n == WAIT_LIMIT)
				abort_on_timeout("a request credit");
			idle();
			n++;
		end
		drive(cpu_go, cpu_rnw, a, d, video_go, va);
	endtask

	task automatic write_page(input int win, input zx_mem_pkg::page_t pg, input logic is_rom);
		@(negedge fclk);
		cpu_req.valid   = 1'b0;
		video_req.valid = 1'b0;
		page_wr         = '{valid: 1'b1, win: 2'(win), page: pg, rom: is_rom};
		sh_page[win]    = pg;
		sh_rom[win]     = is_rom;
	endtask

	// all credits home and every expected response seen
	task automatic drain();
		int n;
		n = 0;
		idle();
		while (cpu_avail() != CPU_DEPTH || video_avail() != VIDEO_DEPTH ||
			cpu_seen != cpu_exp.size() || video_seen != video_exp.size())
		begin
			if (n == WAIT_LIMIT)
				abort_on_timeout("credits and responses to come back");
			idle();
			n++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at = total_errors();
	endtask

	task automatic finish_test();
		int n;
		drain();
		n = total_errors() - errors_at;
		tests_run++;
		if (n != 0)
			tests_failed++;
		$display("%-12s done, %0d error(s)", test_name, n);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0]          r;
		zx_mem_pkg::z_addr_t  a;
		zx_mem_pkg::dram_addr_t va;
		int                   win;
		int                   n;
		int                   writes_before;
		seed      = 41519;
		reset     = 1'b1;
		page_wr   = '0;
		cpu_req   = '0;
		video_req = '0;
		for (int i = 0; i < zx_mem_pkg::NUM_WINDOWS; i++)
		begin
			sh_page[i] = zx_mem_pkg::RESET_PAGE[i];
			sh_rom[i]  = zx_mem_pkg::RESET_ROM[i];
		end
		repeat (5) @(posedge fclk);
		@(negedge fclk);
		reset = 1'b0;

		// also preloads bytes 0 to 15 of pages 1 to 3
		start_test("rw_windows");
		for (int w = 1; w < 4; w++)
			for (int off = 0; off < 16; off++)
			begin
				r = $random(seed);
				send(1'b1, 1'b0, {2'(w), 14'(off)}, r[7:0], 1'b0, '0);
			end
		for (int w = 1; w < 4; w++)
			for (int off = 0; off < 16; off++)
				send(1'b1, 1'b1, {2'(w), 14'(off)}, '0, 1'b0, '0);
		finish_test();

		// window 0 stays rom but points at page 2
		start_test("rom_write");
		write_page(0, 8'd2, 1'b1);
		writes_before = dram_writes;
		send(1'b1, 1'b0, 16'h0005, 8'hc3, 1'b0, '0);
		send(1'b1, 1'b1, 16'h0005, '0, 1'b0, '0);
		send(1'b1, 1'b1, 16'h8005, '0, 1'b0, '0);
		drain();
		assert (dram_writes == writes_before)
		else
		begin
			$display("%s: a write into a rom window reached the DRAM", test_name);
			stim_errors++;
		end
		write_page(0, 8'd0, 1'b1);
		finish_test();

		start_test("remap");
		send(1'b1, 1'b0, 16'h4010, 8'h5a, 1'b0, '0);
		write_page(3, 8'd1, 1'b0);
		send(1'b1, 1'b1, 16'hc010, '0, 1'b0, '0);
		n = 0;
		while (!(dram_cmd.valid && dram_cmd.rnw))
		begin
			if (n == WAIT_LIMIT)
				abort_on_timeout("the remapped read command");
			idle();
			n++;
		end
		assert (dram_cmd.addr == translate_addr(16'hc010))
		else
		begin
			$display("[ERROR] %s dram address: expected %h, actual %h",
				test_name, translate_addr(16'hc010), dram_cmd.addr);
			stim_errors++;
		end
		drain();
		write_page(3, 8'd3, 1'b0);
		finish_test();

		start_test("video_read");
		for (int i = 0; i < 8; i++)
			send(1'b0, 1'b1, '0, '0, 1'b1, {8'd3, 13'(i)});
		finish_test();

		// cpu writes stay off page 3 where the video reads
		start_test("random_mix");
		for (int i = 0; i < RANDOM_OPS; i++)
		begin
			r   = $random(seed);
			win = int'(r[3:2]) % 3;
			if (r[0])
				win = win + 1;
			a   = {2'(win), 10'd0, r[7:4]};
			va  = {8'd3, 10'd0, r[21:19]};
			send(r[17:16] != 2'b00, r[0], a, r[15:8], r[18], va);
		end
		finish_test();

		$display("tests run: %0d, failed: %0d, errors: %0d",
			tests_run, tests_failed, total_errors());
		if (total_errors() == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: test/tb_dram_model.sv
module tb_dram_model
(
	input  logic                   fclk,
	input  zx_bus_pkg::dram_cmd_t  dram_cmd,
	output zx_mem_pkg::dram_word_t dram_rddata
);

	timeunit 1ns;
	timeprecision 1ps;

	// sparse word storage
	zx_mem_pkg::dram_word_t mem [zx_mem_pkg::dram_addr_t];
	zx_mem_pkg::dram_word_t rd_pipe [zx_mem_pkg::DRAM_LATENCY];

	// unwritten words, pattern from all 21 address bits
	function automatic zx_mem_pkg::dram_word_t stored_word(input zx_mem_pkg::dram_addr_t a);
		if (mem.exists(a))
			return mem[a];
		return a[15:0] ^ {a[20:16], 11'h5a5};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// one command per cycle
	////////////////////////////////////////////////////////////////////////////

	always @(posedge fclk)
	begin : access
		zx_mem_pkg::dram_word_t word;
		word = 'x;
		if (dram_cmd.valid)
			word = stored_word(dram_cmd.addr);
		if (dram_cmd.valid && !dram_cmd.rnw)
		begin
			// only lanes set in bsel change
			if (dram_cmd.bsel[0])
				word[7:0] = dram_cmd.wrdata[7:0];
			if (dram_cmd.bsel[1])
				word[15:8] = dram_cmd.wrdata[15:8];
			mem[dram_cmd.addr] = word;
		end
		rd_pipe[0] <= (dram_cmd.valid && dram_cmd.rnw) ? word : 'x;
		for (int i = 1; i < zx_mem_pkg::DRAM_LATENCY; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

	assign dram_rddata = rd_pipe[zx_mem_pkg::DRAM_LATENCY-1];

endmodule

// File: verilog/zmem_path_top.sv
module zmem_path_top
(
	input  logic                   fclk,
	input  logic                   reset,

	input  zx_bus_pkg::page_wr_t   page_wr,

	input  zx_bus_pkg::cpu_req_t   cpu_req,
	output logic                   cpu_credit,

	input  zx_bus_pkg::video_req_t video_req,
	output logic                   video_credit,

	output zx_bus_pkg::dram_cmd_t  dram_cmd,
	input  zx_mem_pkg::dram_word_t dram_rddata,

	output zx_bus_pkg::cpu_rsp_t   cpu_rsp,
	output zx_bus_pkg::video_rsp_t video_rsp
);

	zx_bus_pkg::mem_req_t cpu_push;
	zx_bus_pkg::mem_req_t cpu_head;
	zx_bus_pkg::mem_req_t video_push;
	zx_bus_pkg::mem_req_t video_head;
	zx_bus_pkg::mem_req_t grant_req;

	logic cpu_pop;
	logic video_pop;

	// video fetch becomes a word read
	assign video_push = '{
		valid:  video_req.valid,
		rnw:    1'b1,
		drop:   1'b0,
		addr:   video_req.addr,
		bsel:   zx_mem_pkg::BSEL_WORD,
		wrdata: '0,
		src:    zx_bus_pkg::SRC_VIDEO
	};

	zmem_pager i_zmem_pager
	(
		.fclk    (fclk),
		.reset   (reset),
		.page_wr (page_wr),
		.cpu_req (cpu_req),
		.mem_req (cpu_push)
	);

	req_credit_fifo #(.DEPTH(zx_mem_pkg::CPU_QUEUE_DEPTH)) i_cpu_fifo
	(
		.fclk(fclk), .reset(reset),
		.push(cpu_push), .head(cpu_head), .pop(cpu_pop), .credit(cpu_credit)
	);

	req_credit_fifo #(.DEPTH(zx_mem_pkg::VIDEO_QUEUE_DEPTH)) i_video_fifo
	(
		.fclk(fclk), .reset(reset),
		.push(video_push), .head(video_head), .pop(video_pop), .credit(video_credit)
	);

	dram_arbiter i_dram_arbiter
	(
		.fclk       (fclk),
		.reset      (reset),
		.cpu_head   (cpu_head),
		.video_head (video_head),
		.cpu_pop    (cpu_pop),
		.video_pop  (video_pop),
		.grant_req  (grant_req)
	);

	dram_sequencer i_dram_sequencer
	(
		.fclk        (fclk),
		.reset       (reset),
		.grant_req   (grant_req),
		.dram_cmd    (dram_cmd),
		.dram_rddata (dram_rddata),
		.cpu_rsp     (cpu_rsp),
		.video_rsp   (video_rsp)
	);

endmodule

// File: verilog/dram_sequencer.sv
module dram_sequencer
(
	input  logic                   fclk,
	input  logic                   reset,

	input  zx_bus_pkg::mem_req_t   grant_req,

	output zx_bus_pkg::dram_cmd_t  dram_cmd,
	input  zx_mem_pkg::dram_word_t dram_rddata,

	output zx_bus_pkg::cpu_rsp_t   cpu_rsp,
	output zx_bus_pkg::video_rsp_t video_rsp
);

	// one extra stage so the tag lines up with returning data
	localparam int TAG_LEN = zx_mem_pkg::DRAM_LATENCY + 1;

	typedef struct packed
	{
		logic              valid;
		logic              src;
		zx_mem_pkg::bsel_t bsel;
	} rd_tag_t;

	rd_tag_t tag_line [TAG_LEN];
	rd_tag_t tag_out;

	zx_mem_pkg::byte_t rd_byte;

	////////////////////////////////////////////////////////////////////////////
	// command issue
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		dram_cmd.rnw    <= grant_req.rnw;
		dram_cmd.addr   <= grant_req.addr;
		// video always reads a full word
		if (grant_req.src == zx_bus_pkg::SRC_VIDEO)
			dram_cmd.bsel <= zx_mem_pkg::BSEL_WORD;
		else
			dram_cmd.bsel <= grant_req.bsel;
		// byte on both halves, bsel picks the lane
		dram_cmd.wrdata <= {2{grant_req.wrdata}};

		if (reset)
			dram_cmd.valid <= 1'b0;
		else
			dram_cmd.valid <= grant_req.valid;
	end

	////////////////////////////////////////////////////////////////////////////
	// in-flight read tags
	////////////////////////////////////////////////////////////////////////////

	// stage k is the k-th cycle after the command went out
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			for (int i = 0; i < TAG_LEN; i++)
				tag_line[i] <= '0;
		end
		else
		begin
			tag_line[0].valid <= grant_req.valid & grant_req.rnw;
			tag_line[0].src   <= grant_req.src;
			tag_line[0].bsel  <= grant_req.bsel;
			for (int i = 1; i < TAG_LEN; i++)
				tag_line[i] <= tag_line[i-1];
		end
	end

	assign tag_out = tag_line[TAG_LEN-1];

	// high lane for odd addresses
	assign rd_byte = tag_out.bsel[1] ?
		dram_rddata[zx_mem_pkg::BYTE_W +: zx_mem_pkg::BYTE_W] :
		dram_rddata[0 +: zx_mem_pkg::BYTE_W];

	always_ff @(posedge fclk)
	begin
		cpu_rsp.data   <= rd_byte;
		video_rsp.data <= dram_rddata;

		if (reset)
		begin
			cpu_rsp.valid   <= 1'b0;
			video_rsp.valid <= 1'b0;
		end
		else
		begin
			cpu_rsp.valid   <= tag_out.valid & (tag_out.src == zx_bus_pkg::SRC_CPU);
			video_rsp.valid <= tag_out.valid & (tag_out.src == zx_bus_pkg::SRC_VIDEO);
		end
	end

endmodule

// File: verilog/dram_arbiter.sv
module dram_arbiter
(
	input  logic                 fclk,
	input  logic                 reset,

	input  zx_bus_pkg::mem_req_t cpu_head,
	input  zx_bus_pkg::mem_req_t video_head,

	output logic                 cpu_pop,
	output logic                 video_pop,

	output zx_bus_pkg::mem_req_t grant_req
);

	zx_bus_pkg::arb_state_t last_grant;

	// heads that need a dram cycle
	logic cpu_ok;
	logic video_ok;
	logic pick_cpu;

	assign cpu_ok   = cpu_head.valid & ~cpu_head.drop;
	assign video_ok = video_head.valid & ~video_head.drop;

	// on a tie the side not served last time wins
	assign pick_cpu = cpu_ok & (~video_ok | (last_grant == zx_bus_pkg::last_video));

	assign cpu_pop   = pick_cpu;
	assign video_pop = video_ok & ~pick_cpu;

	////////////////////////////////////////////////////////////////////////////
	// grant mux
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		grant_req = '0;
		if (cpu_pop)
			grant_req = cpu_head;
		else if (video_pop)
			grant_req = video_head;
	end

	always_ff @(posedge fclk)
	begin
		if (reset)
			last_grant <= zx_bus_pkg::last_video;
		else if (cpu_pop)
			last_grant <= zx_bus_pkg::last_cpu;
		else if (video_pop)
			last_grant <= zx_bus_pkg::last_video;
	end

endmodule

// File: verilog/req_credit_fifo.sv
module req_credit_fifo
#(
	parameter int DEPTH = 4
)
(
	input  logic                 fclk,
	input  logic                 reset,

	input  zx_bus_pkg::mem_req_t push,
	output zx_bus_pkg::mem_req_t head,
	input  logic                 pop,

	output logic                 credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	zx_bus_pkg::mem_req_t buf_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic do_push;
	logic do_pop;

	// wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_comb
	begin
		head       = buf_mem[rd_ptr];
		head.valid = (count != '0);
	end

	// dropped entries leave by themselves
	assign do_push = push.valid;
	assign do_pop  = head.valid & (pop | head.drop);
	assign credit  = do_pop;

	always_ff @(posedge fclk)
	begin
		if (do_push)
			buf_mem[wr_ptr] <= push;
	end

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);

			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: verilog/zmem_pager.sv
module zmem_pager
(
	input  logic                 fclk,
	input  logic                 reset,

	input  zx_bus_pkg::page_wr_t page_wr,

	input  zx_bus_pkg::cpu_req_t cpu_req,
	output zx_bus_pkg::mem_req_t mem_req
);

	// per-window page and rom flag
	zx_mem_pkg::page_t                  page_reg [zx_mem_pkg::NUM_WINDOWS];
	logic [zx_mem_pkg::NUM_WINDOWS-1:0] romnram;

	// window of the current request
	zx_mem_pkg::win_idx_t win;
	zx_mem_pkg::page_t    win_page;
	logic                 win_rom;

	////////////////////////////////////////////////////////////////////////////
	// page registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			for (int i = 0; i < zx_mem_pkg::NUM_WINDOWS; i++)
			begin
				page_reg[i] <= zx_mem_pkg::RESET_PAGE[i];
				romnram[i]  <= zx_mem_pkg::RESET_ROM[i];
			end
		end
		else if (page_wr.valid)
		begin
			page_reg[page_wr.win] <= page_wr.page;
			romnram[page_wr.win]  <= page_wr.rom;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// address translation
	////////////////////////////////////////////////////////////////////////////

	// old page map applies to a request that meets a page write
	assign win      = cpu_req.addr[zx_mem_pkg::WIN_LSB +: zx_mem_pkg::WIN_IDX_W];
	assign win_page = page_reg[win];
	assign win_rom  = romnram[win];

	always_ff @(posedge fclk)
	begin
		mem_req.rnw    <= cpu_req.rnw;
		// rom writes still go to the queue so that their credit comes back
		mem_req.drop   <= ~cpu_req.rnw & win_rom;
		// page on top, word offset inside the window below
		mem_req.addr   <= {win_page, cpu_req.addr[zx_mem_pkg::WIN_LSB-1:1]};
		mem_req.bsel   <= cpu_req.addr[0] ? zx_mem_pkg::BSEL_HI : zx_mem_pkg::BSEL_LO;
		mem_req.wrdata <= cpu_req.wrdata;
		mem_req.src    <= zx_bus_pkg::SRC_CPU;

		if (reset)
			mem_req.valid <= 1'b0;
		else
			mem_req.valid <= cpu_req.valid;
	end

endmodule

// File: verilog/zx_bus_pkg.sv
package zx_bus_pkg;

	// request source tag
	localparam logic SRC_CPU   = 1'b0;
	localparam logic SRC_VIDEO = 1'b1;

	// z80 memory request as seen at the cpu side
	typedef struct packed
	{
		logic                valid;
		logic                rnw;
		zx_mem_pkg::z_addr_t addr;
		zx_mem_pkg::byte_t   wrdata;
	} cpu_req_t;

	// one-shot page register write
	typedef struct packed
	{
		logic                 valid;
		zx_mem_pkg::win_idx_t win;
		zx_mem_pkg::page_t    page;
		logic                 rom;
	} page_wr_t;

	// translated request, drop marks a write into a rom window
	typedef struct packed
	{
		logic                   valid;
		logic                   rnw;
		logic                   drop;
		zx_mem_pkg::dram_addr_t addr;
		zx_mem_pkg::bsel_t      bsel;
		zx_mem_pkg::byte_t      wrdata;
		logic                   src;
	} mem_req_t;

	typedef struct packed
	{
		logic                   valid;
		zx_mem_pkg::dram_addr_t addr;
	} video_req_t;

	typedef struct packed
	{
		logic                   valid;
		logic                   rnw;
		zx_mem_pkg::dram_addr_t addr;
		zx_mem_pkg::bsel_t      bsel;
		zx_mem_pkg::dram_word_t wrdata;
	} dram_cmd_t;

	typedef struct packed
	{
		logic              valid;
		zx_mem_pkg::byte_t data;
	} cpu_rsp_t;

	typedef struct packed
	{
		logic                   valid;
		zx_mem_pkg::dram_word_t data;
	} video_rsp_t;

	// who got the dram last time
	typedef enum logic
	{
		last_cpu,
		last_video
	} arb_state_t;

endpackage

// File: verilog/zx_mem_pkg.sv
package zx_mem_pkg;

	// field widths
	localparam int Z_ADDR_W    = 16;
	localparam int PAGE_W      = 8;
	localparam int WIN_IDX_W   = 2;
	localparam int DRAM_ADDR_W = 21;
	localparam int DRAM_WORD_W = 16;
	localparam int BYTE_W      = 8;
	localparam int BSEL_W      = 2;

	typedef logic [Z_ADDR_W-1:0]    z_addr_t;
	typedef logic [PAGE_W-1:0]      page_t;
	typedef logic [WIN_IDX_W-1:0]   win_idx_t;
	typedef logic [DRAM_ADDR_W-1:0] dram_addr_t;
	typedef logic [DRAM_WORD_W-1:0] dram_word_t;
	typedef logic [BYTE_W-1:0]      byte_t;
	typedef logic [BSEL_W-1:0]      bsel_t;

	// four 16k windows, window number in the top two address bits
	localparam int NUM_WINDOWS = 4;
	localparam int WIN_LSB     = Z_ADDR_W - WIN_IDX_W;

	// read command to read data, in fclk cycles
	localparam int DRAM_LATENCY = 2;

	localparam int CPU_QUEUE_DEPTH   = 4;
	localparam int VIDEO_QUEUE_DEPTH = 2;

	// byte lanes, bit 0 is the low byte
	localparam bsel_t BSEL_LO   = 2'b01;
	localparam bsel_t BSEL_HI   = 2'b10;
	localparam bsel_t BSEL_WORD = 2'b11;

	// window i maps page i after reset, only window 0 is rom
	localparam page_t RESET_PAGE [NUM_WINDOWS] = '{8'd0, 8'd1, 8'd2, 8'd3};
	localparam logic [NUM_WINDOWS-1:0] RESET_ROM = 4'b0001;

endpackage
